// ==== common/rover_pkg.sv ====
package rover_pkg;

    typedef enum logic [1:0] {
        mode_idle = 2'd0,
        mode_cam  = 2'd1,
        mode_ir   = 2'd2
    } mode_e;

    typedef enum logic [1:0] {
        cam_search = 2'd0,
        cam_follow = 2'd1,
        cam_pause  = 2'd3
    } cam_state_e;

    typedef enum logic [3:0] {
        drv_stop     = 4'd0,
        drv_left     = 4'd1,
        drv_right    = 4'd2,
        drv_slow     = 4'd3,
        drv_medium   = 4'd4,
        drv_fast     = 4'd5,
        drv_reverse  = 4'd6,
        drv_lreverse = 4'd7,
        drv_rreverse = 4'd8
    } drive_e;

    typedef enum logic [7:0] {
        btn_reverse  = 8'h00,
        btn_fast     = 8'h02,
        btn_medium   = 8'h05,
        btn_left     = 8'h07,
        btn_slow     = 8'h08,
        btn_right    = 8'h09,
        btn_stop     = 8'h0C,
        btn_cam      = 8'h0F,     // Mode buttons
        btn_idle     = 8'h10,
        btn_lreverse = 8'h11,
        btn_ir       = 8'h13,
        btn_rreverse = 8'h17
    } ir_code_e;

    typedef enum logic [2:0] {
        dir_none   = 3'd0,
        dir_left   = 3'd1,
        dir_right  = 3'd2,
        dir_center = 3'd3
    } cam_dir_e;

    // Active low, bit 6 is segment g
    localparam logic [6:0] seg_blank = 7'b1111111;
    localparam logic [6:0] seg_i     = 7'b1111001;
    localparam logic [6:0] seg_d     = 7'b0100001;
    localparam logic [6:0] seg_c     = 7'b1000110;
    localparam logic [6:0] seg_a     = 7'b0001000;
    localparam logic [6:0] seg_r     = 7'b0101111;
    localparam logic [6:0] seg_s     = 7'b0010010;
    localparam logic [6:0] seg_f     = 7'b0001110;
    localparam logic [6:0] seg_p     = 7'b0001100;
    localparam logic [6:0] seg_e     = 7'b0000110;
    localparam logic [6:0] seg_g     = 7'b0000010;
    localparam logic [6:0] seg_h     = 7'b0001001;
    localparam logic [6:0] seg_o     = 7'b1000000;
    localparam logic [6:0] seg_t     = 7'b0001111;
    localparam logic [6:0] seg_l     = 7'b1000111;
    localparam logic [6:0] seg_1     = 7'b1111001;
    localparam logic [6:0] seg_2     = 7'b0100100;
    localparam logic [6:0] seg_3     = 7'b0110000;

endpackage

// ==== mode_fsm/mode_fsm.sv ====
module mode_fsm (
    input  logic                  clk_50,
    input  logic                  rst_n,
    input  logic                  ir_valid,
    input  rover_pkg::ir_code_e   ir_code,
    input  rover_pkg::cam_dir_e   cam_direction,
    input  logic [1:0]            speed,
    input  logic                  orange_detected,
    output rover_pkg::mode_e      mode,
    output rover_pkg::cam_state_e cam_state,
    output rover_pkg::drive_e     drive_state,
    output logic                  mode_change
);
    import rover_pkg::*;

    mode_e      next_mode;
    cam_state_e next_cam_state;
    drive_e     next_drive;
    drive_e     ir_drive;
    logic       ir_drive_hit;

    always_comb begin
        next_mode = mode;
        if (ir_valid) begin
            case (mode)
                mode_idle: begin
                    if (ir_code == btn_cam)
                        next_mode = mode_cam;
                    else if (ir_code == btn_ir)
                        next_mode = mode_ir;
                end
                mode_cam: begin
                    if (ir_code == btn_ir)
                        next_mode = mode_ir;
                    else if (ir_code == btn_idle)
                        next_mode = mode_idle;
                end
                mode_ir: begin
                    if (ir_code == btn_cam)
                        next_mode = mode_cam;
                    else if (ir_code == btn_idle)
                        next_mode = mode_idle;
                end
                default: next_mode = mode_idle;
            endcase
        end
    end

    always_comb begin
        case (cam_state)
            cam_search, cam_follow: next_cam_state = orange_detected ? cam_follow : cam_search;
            default:    next_cam_state = cam_search;      // Entering camera mode
        endcase
        if (next_mode != mode_cam)
            next_cam_state = cam_pause;
    end

    // Manual drive buttons, only valid on a strobe
    always_comb begin
        ir_drive_hit = ir_valid;
        ir_drive     = drv_stop;
        case (ir_code)
            btn_stop:     ir_drive = drv_stop;
            btn_left:     ir_drive = drv_left;
            btn_right:    ir_drive = drv_right;
            btn_fast:     ir_drive = drv_fast;
            btn_medium:   ir_drive = drv_medium;
            btn_slow:     ir_drive = drv_slow;
            btn_reverse:  ir_drive = drv_reverse;
            btn_lreverse: ir_drive = drv_lreverse;
            btn_rreverse: ir_drive = drv_rreverse;
            default:      ir_drive_hit = 1'b0;
        endcase
    end

    always_comb begin
        next_drive = drv_stop;
        case (mode)
            mode_cam: begin
                if (speed != 2'b11 && next_cam_state != cam_pause) begin
                    case (cam_direction)
                        dir_left:  next_drive = drv_left;
                        dir_right: next_drive = drv_right;
                        dir_center: begin
                            if (next_cam_state == cam_follow) begin
                                case (speed)
                                    2'd0:    next_drive = drv_slow;
                                    2'd1:    next_drive = drv_medium;
                                    default: next_drive = drv_fast;
                                endcase
                            end
                        end
                        default: next_drive = drv_stop;
                    endcase
                end
            end
            mode_ir: begin
                if (speed == 2'b11)
                    next_drive = drv_stop;
                else if (orange_detected && cam_direction == dir_left)
                    next_drive = drv_right;               // Turn away from obstacle
                else if (orange_detected && cam_direction == dir_right)
                    next_drive = drv_left;
                else if (ir_drive_hit)
                    next_drive = ir_drive;
                else
                    next_drive = drive_state;             // Hold last press
            end
            default: next_drive = drv_stop;
        endcase
    end

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            mode        <= mode_idle;
            cam_state   <= cam_pause;
            drive_state <= drv_stop;
            mode_change <= 1'b0;
        end else begin
            mode        <= next_mode;
            cam_state   <= next_cam_state;
            drive_state <= next_drive;
            mode_change <= (next_mode != mode) || (next_cam_state != cam_state);
        end
    end

    a_idle_stops: assert property (@(posedge clk_50) disable iff (!rst_n)
        mode == mode_idle |=> drive_state == drv_stop);

    a_pause_outside_cam: assert property (@(posedge clk_50) disable iff (!rst_n)
        mode != mode_cam |-> cam_state == cam_pause);

endmodule

// ==== rtl/motor_pwm.sv ====
module motor_pwm #(
    parameter int PWM_PERIOD = 100
) (
    input  logic              clk_50,
    input  logic              rst_n,
    input  rover_pkg::drive_e drive_state,
    input  logic              mode_change,
    output logic              motor_left_pwm,
    output logic              motor_right_pwm,
    output logic              motor_left_rev,
    output logic              motor_right_rev
);
    import rover_pkg::*;

    localparam int CNT_W = $clog2(PWM_PERIOD);
    localparam logic [CNT_W-1:0] DUTY_QUARTER = CNT_W'(PWM_PERIOD / 4);
    localparam logic [CNT_W-1:0] DUTY_HALF    = CNT_W'(PWM_PERIOD / 2);
    localparam logic [CNT_W-1:0] DUTY_3QUART  = CNT_W'((PWM_PERIOD * 3) / 4);
    localparam logic [CNT_W-1:0] CNT_LAST     = CNT_W'(PWM_PERIOD - 1);

    logic [CNT_W-1:0] pwm_cnt;
    logic [CNT_W-1:0] left_duty;
    logic [CNT_W-1:0] right_duty;

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n)
            pwm_cnt <= '0;
        else if (mode_change || pwm_cnt == CNT_LAST)
            pwm_cnt <= '0;                                // Fresh period on new mode
        else
            pwm_cnt <= pwm_cnt + 1'b1;
    end

    always_comb begin
        left_duty       = '0;
        right_duty      = '0;
        motor_left_rev  = 1'b0;
        motor_right_rev = 1'b0;
        case (drive_state)
            drv_slow: begin
                left_duty  = DUTY_QUARTER;
                right_duty = DUTY_QUARTER;
            end
            drv_medium: begin
                left_duty  = DUTY_HALF;
                right_duty = DUTY_HALF;
            end
            drv_fast: begin
                left_duty  = DUTY_3QUART;
                right_duty = DUTY_3QUART;
            end
            drv_left:  right_duty = DUTY_HALF;            // Pivot on left wheel
            drv_right: left_duty  = DUTY_HALF;
            drv_reverse: begin
                left_duty       = DUTY_HALF;
                right_duty      = DUTY_HALF;
                motor_left_rev  = 1'b1;
                motor_right_rev = 1'b1;
            end
            drv_lreverse: begin
                right_duty      = DUTY_HALF;
                motor_right_rev = 1'b1;
            end
            drv_rreverse: begin
                left_duty      = DUTY_HALF;
                motor_left_rev = 1'b1;
            end
            default: ;                                    // Stop
        endcase
    end

    assign motor_left_pwm  = pwm_cnt < left_duty;
    assign motor_right_pwm = pwm_cnt < right_duty;

    a_cnt_in_range: assert property (@(posedge clk_50) disable iff (!rst_n)
        pwm_cnt < PWM_PERIOD);

    a_no_rev_on_stop: assert property (@(posedge clk_50) disable iff (!rst_n)
        drive_state == drv_stop |-> !motor_left_rev && !motor_right_rev);

endmodule

// ==== rtl/status_display.sv ====
module status_display (
    input  rover_pkg::mode_e      mode,
    input  rover_pkg::cam_state_e cam_state,
    input  rover_pkg::drive_e     drive_state,
    output logic [6:0]            hex0,
    output logic [6:0]            hex1,
    output logic [6:0]            hex2,
    output logic [6:0]            hex3,
    output logic [6:0]            hex4,
    output logic [6:0]            hex5,
    output logic [6:0]            hex6,
    output logic [6:0]            hex7
);
    import rover_pkg::*;

    always_comb begin
        case (mode)
            mode_idle: {hex7, hex6} = {seg_i, seg_d};
            mode_cam:  {hex7, hex6} = {seg_c, seg_a};
            mode_ir:   {hex7, hex6} = {seg_i, seg_r};
            default:   {hex7, hex6} = {seg_e, seg_r};     // Unused encoding
        endcase
    end

    assign hex5 = seg_blank;

    always_comb begin
        case (cam_state)
            cam_search: hex4 = seg_s;
            cam_follow: hex4 = seg_f;
            cam_pause:  hex4 = seg_p;
            default:    hex4 = seg_blank;
        endcase
    end

    always_comb begin
        hex3 = seg_blank;
        hex2 = seg_blank;
        hex1 = seg_blank;
        hex0 = seg_blank;
        case (drive_state)
            drv_left: begin
                hex3 = seg_l;
                hex2 = seg_e;
                hex1 = seg_f;
                hex0 = seg_t;
            end
            drv_right: begin
                hex3 = seg_r;
                hex2 = seg_g;
                hex1 = seg_h;
                hex0 = seg_t;
            end
            drv_slow, drv_medium, drv_fast: begin
                hex3 = seg_s;
                hex2 = seg_p;
                if (drive_state == drv_slow)
                    hex0 = seg_1;
                else if (drive_state == drv_medium)
                    hex0 = seg_2;
                else
                    hex0 = seg_3;
            end
            drv_stop: begin
                hex3 = seg_s;
                hex2 = seg_t;
                hex1 = seg_o;
                hex0 = seg_p;
            end
            default: ;                                    // Reverse commands stay dark
        endcase
    end

endmodule

// ==== rtl/rover_top.sv ====
module rover_top #(
    parameter int PWM_PERIOD = 100
) (
    input  logic                  clk_50,
    input  logic                  rst_n,
    input  logic                  ir_valid,
    input  rover_pkg::ir_code_e   ir_code,
    input  rover_pkg::cam_dir_e   cam_direction,
    input  logic [1:0]            speed,
    input  logic                  orange_detected,
    output rover_pkg::mode_e      mode,
    output rover_pkg::cam_state_e cam_state,
    output rover_pkg::drive_e     drive_state,
    output logic                  motor_left_pwm,
    output logic                  motor_right_pwm,
    output logic                  motor_left_rev,
    output logic                  motor_right_rev,
    output logic [6:0]            hex0,
    output logic [6:0]            hex1,
    output logic [6:0]            hex2,
    output logic [6:0]            hex3,
    output logic [6:0]            hex4,
    output logic [6:0]            hex5,
    output logic [6:0]            hex6,
    output logic [6:0]            hex7
);

    logic mode_change;                                    // Restarts PWM period

    mode_fsm u_mode_fsm (
        .clk_50          (clk_50),
        .rst_n           (rst_n),
        .ir_valid        (ir_valid),
        .ir_code         (ir_code),
        .cam_direction   (cam_direction),
        .speed           (speed),
        .orange_detected (orange_detected),
        .mode            (mode),
        .cam_state       (cam_state),
        .drive_state     (drive_state),
        .mode_change     (mode_change)
    );

    motor_pwm #(
        .PWM_PERIOD (PWM_PERIOD)
    ) u_motor_pwm (
        .clk_50          (clk_50),
        .rst_n           (rst_n),
        .drive_state     (drive_state),
        .mode_change     (mode_change),
        .motor_left_pwm  (motor_left_pwm),
        .motor_right_pwm (motor_right_pwm),
        .motor_left_rev  (motor_left_rev),
        .motor_right_rev (motor_right_rev)
    );

    status_display u_status_display (
        .mode        (mode),
        .cam_state   (cam_state),
        .drive_state (drive_state),
        .hex0        (hex0),
        .hex1        (hex1),
        .hex2        (hex2),
        .hex3        (hex3),
        .hex4        (hex4),
        .hex5        (hex5),
        .hex6        (hex6),
        .hex7        (hex7)
    );

endmodule

// ==== verification/rover_tb.sv ====
module rover_tb;
    import rover_pkg::*;

    localparam int PWM_PERIOD = 20;

    logic       clk_50;
    logic       rst_n;
    logic       ir_valid;
    ir_code_e   ir_code;
    cam_dir_e   cam_direction;
    logic [1:0] speed;
    logic       orange_detected;
    mode_e      mode;
    cam_state_e cam_state;
    drive_e     drive_state;
    logic       motor_left_pwm;
    logic       motor_right_pwm;
    logic       motor_left_rev;
    logic       motor_right_rev;
    logic [6:0] hex0;
    logic [6:0] hex1;
    logic [6:0] hex2;
    logic [6:0] hex3;
    logic [6:0] hex4;
    logic [6:0] hex5;
    logic [6:0] hex6;
    logic [6:0] hex7;

    // Stimulus and expected state one cycle later
    logic        tab_valid[$];
    logic [7:0]  tab_code[$];
    cam_dir_e    tab_dir[$];
    logic [1:0]  tab_speed[$];
    logic        tab_orange[$];
    mode_e       tab_mode[$];
    cam_state_e  tab_cam[$];
    drive_e      tab_drive[$];
    logic [55:0] tab_hex[$];

    int seed        = 17;
    int cycles      = 0;
    int cycle_limit = 0;

    rover_top #(
        .PWM_PERIOD (PWM_PERIOD)
    ) uut (.*);

    initial begin
        clk_50 = 1'b0;
        forever #20 clk_50 = ~clk_50;
    end

    always @(posedge clk_50) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("ERROR: %s = 0x%0h, expected 0x%0h", name, got, want);
        abort_run();
    endtask

    task automatic mode_check(input string name, input mode_e got, input mode_e want);
        if (got !== want)
            report_mismatch(name, got, want);
    endtask

    task automatic cam_state_check(input string name, input cam_state_e got,
                                   input cam_state_e want);
        if (got !== want)
            report_mismatch(name, got, want);
    endtask

    task automatic drive_check(input string name, input drive_e got, input drive_e want);
        if (got !== want)
            report_mismatch(name, got, want);
    endtask

    task automatic segment_check(input string name, input logic [6:0] got,
                                 input logic [6:0] want);
        if (got !== want)
            report_mismatch(name, got, want);
    endtask

    task automatic count_check(input string name, input int got, input int want);
        if (got != want)
            report_mismatch(name, got, want);
    endtask

    task automatic flag_check(input string name, input logic got, input logic want);
        if (got !== want)
            report_mismatch(name, got, want);
    endtask

    // Expected letters: mode on digits 7 and 6, sub-state on 4, command on 3 to 0
    function automatic logic [55:0] letters_for(input mode_e m, input cam_state_e c,
                                                input drive_e d);
        logic [13:0] mode_word;
        logic [6:0]  cam_letter;
        logic [27:0] drive_word;
        case (m)
            mode_idle: mode_word = {seg_i, seg_d};
            mode_cam:  mode_word = {seg_c, seg_a};
            mode_ir:   mode_word = {seg_i, seg_r};
            default:   mode_word = {2{seg_blank}};
        endcase
        case (c)
            cam_search: cam_letter = seg_s;
            cam_follow: cam_letter = seg_f;
            default:    cam_letter = seg_p;
        endcase
        case (d)
            drv_left:   drive_word = {seg_l, seg_e, seg_f, seg_t};
            drv_right:  drive_word = {seg_r, seg_g, seg_h, seg_t};
            drv_slow:   drive_word = {seg_s, seg_p, seg_blank, seg_1};
            drv_medium: drive_word = {seg_s, seg_p, seg_blank, seg_2};
            drv_fast:   drive_word = {seg_s, seg_p, seg_blank, seg_3};
            drv_stop:   drive_word = {seg_s, seg_t, seg_o, seg_p};
            default:    drive_word = {4{seg_blank}};     // Reverse commands
        endcase
        return {mode_word, seg_blank, cam_letter, drive_word};
    endfunction

    function automatic logic is_button_code(input logic [7:0] code);
        return code inside {8'h00, 8'h02, 8'h05, 8'h07, 8'h08, 8'h09,
                            8'h0C, 8'h0F, 8'h10, 8'h11, 8'h13, 8'h17};
    endfunction

    task automatic display_check(input logic [55:0] want);
        logic [55:0] got;
        got = {hex7, hex6, hex5, hex4, hex3, hex2, hex1, hex0};
        for (int d = 0; d < 8; d++)
            segment_check($sformatf("hex%0d", d), got[d*7 +: 7], want[d*7 +: 7]);
    endtask

    task automatic add_step(input logic v, input logic [7:0] code, input cam_dir_e dir,
                            input logic [1:0] spd, input logic org, input mode_e m,
                            input cam_state_e c, input drive_e d);
        tab_valid.push_back(v);
        tab_code.push_back(code);
        tab_dir.push_back(dir);
        tab_speed.push_back(spd);
        tab_orange.push_back(org);
        tab_mode.push_back(m);
        tab_cam.push_back(c);
        tab_drive.push_back(d);
        tab_hex.push_back(letters_for(m, c, d));
    endtask

    // Repeats the last step with strobes of codes that belong to no button
    task automatic add_noise(input int count);
        int         last;
        logic [7:0] code;
        last = tab_valid.size() - 1;
        repeat (count) begin
            code = 8'($random(seed));
            while (is_button_code(code))
                code = 8'($random(seed));
            add_step(1'b1, code, tab_dir[last], tab_speed[last], tab_orange[last],
                     tab_mode[last], tab_cam[last], tab_drive[last]);
        end
    endtask

    task automatic build_table();
        add_step(1'b0, btn_cam, dir_left, 2'd1, 1'b1, mode_idle, cam_pause, drv_stop);
        add_step(1'b1, btn_idle, dir_none, 2'd0, 1'b0, mode_idle, cam_pause, drv_stop);
        add_noise(3);
        add_step(1'b1, btn_cam, dir_none, 2'd0, 1'b0, mode_cam, cam_search, drv_stop);
        add_step(1'b0, btn_stop, dir_left, 2'd1, 1'b0, mode_cam, cam_search, drv_left);
        add_step(1'b0, btn_stop, dir_right, 2'd1, 1'b0, mode_cam, cam_search, drv_right);
        add_step(1'b0, btn_stop, dir_center, 2'd1, 1'b0, mode_cam, cam_search, drv_stop);
        add_step(1'b0, btn_stop, dir_center, 2'd0, 1'b1, mode_cam, cam_follow, drv_slow);
        add_step(1'b0, btn_stop, dir_center, 2'd1, 1'b1, mode_cam, cam_follow, drv_medium);
        add_step(1'b0, btn_stop, dir_center, 2'd2, 1'b1, mode_cam, cam_follow, drv_fast);
        add_step(1'b0, btn_stop, dir_center, 2'd3, 1'b1, mode_cam, cam_follow, drv_stop);
        add_step(1'b0, btn_stop, dir_left, 2'd2, 1'b1, mode_cam, cam_follow, drv_left);
        add_step(1'b0, btn_stop, dir_none, 2'd2, 1'b1, mode_cam, cam_follow, drv_stop);
        add_step(1'b0, btn_stop, dir_center, 2'd2, 1'b0, mode_cam, cam_search, drv_stop);
        add_step(1'b1, btn_cam, dir_left, 2'd2, 1'b0, mode_cam, cam_search, drv_left);
        add_step(1'b1, btn_ir, dir_left, 2'd2, 1'b0, mode_ir, cam_pause, drv_stop);
        add_step(1'b1, btn_left, dir_none, 2'd0, 1'b0, mode_ir, cam_pause, drv_left);
        add_step(1'b0, btn_stop, dir_none, 2'd0, 1'b0, mode_ir, cam_pause, drv_left);
        add_step(1'b0, btn_stop, dir_none, 2'd0, 1'b0, mode_ir, cam_pause, drv_left);
        add_step(1'b1, btn_fast, dir_none, 2'd0, 1'b0, mode_ir, cam_pause, drv_fast);
        add_noise(3);
        add_step(1'b0, btn_stop, dir_left, 2'd0, 1'b1, mode_ir, cam_pause, drv_right);
        add_step(1'b1, btn_slow, dir_right, 2'd0, 1'b1, mode_ir, cam_pause, drv_left);
        add_step(1'b0, btn_stop, dir_none, 2'd0, 1'b0, mode_ir, cam_pause, drv_left);
        add_step(1'b1, btn_reverse, dir_none, 2'd0, 1'b0, mode_ir, cam_pause, drv_reverse);
        add_step(1'b1, btn_lreverse, dir_none, 2'd0, 1'b0, mode_ir, cam_pause, drv_lreverse);
        add_step(1'b1, btn_rreverse, dir_none, 2'd0, 1'b0, mode_ir, cam_pause, drv_rreverse);
        add_step(1'b1, btn_medium, dir_none, 2'd3, 1'b0, mode_ir, cam_pause, drv_stop);
        add_step(1'b1, btn_right, dir_none, 2'd0, 1'b0, mode_ir, cam_pause, drv_right);
        add_step(1'b1, btn_stop, dir_none, 2'd0, 1'b0, mode_ir, cam_pause, drv_stop);
        add_step(1'b1, btn_medium, dir_none, 2'd0, 1'b0, mode_ir, cam_pause, drv_medium);
        add_step(1'b0, btn_fast, dir_none, 2'd0, 1'b0, mode_ir, cam_pause, drv_medium);
        add_step(1'b1, btn_cam, dir_none, 2'd0, 1'b0, mode_cam, cam_search, drv_medium);
        add_step(1'b0, btn_stop, dir_center, 2'd0, 1'b1, mode_cam, cam_follow, drv_slow);
        add_step(1'b1, btn_idle, dir_center, 2'd0, 1'b1, mode_idle, cam_pause, drv_stop);
        add_step(1'b1, btn_ir, dir_none, 2'd0, 1'b0, mode_ir, cam_pause, drv_stop);
        add_step(1'b1, btn_idle, dir_none, 2'd0, 1'b0, mode_idle, cam_pause, drv_stop);
    endtask

    task automatic measure_duty(input ir_code_e code, input drive_e want_drive,
                                input int want_left, input int want_right,
                                input logic want_lrev, input logic want_rrev);
        int high_left;
        int high_right;
        high_left  = 0;
        high_right = 0;
        ir_valid   = 1'b1;
        ir_code    = code;
        @(posedge clk_50);
        #2;
        ir_valid = 1'b0;
        drive_check("drive_state", drive_state, want_drive);
        flag_check("motor_left_rev", motor_left_rev, want_lrev);
        flag_check("motor_right_rev", motor_right_rev, want_rrev);
        repeat (PWM_PERIOD) begin                      // Any full window holds one period
            if (motor_left_pwm)
                high_left++;
            if (motor_right_pwm)
                high_right++;
            @(posedge clk_50);
            #2;
        end
        count_check("motor_left_pwm high cycles", high_left, want_left);
        count_check("motor_right_pwm high cycles", high_right, want_right);
    endtask

    initial begin
        rst_n           = 1'b0;
        ir_valid        = 1'b0;
        ir_code         = btn_stop;
        cam_direction   = dir_none;
        speed           = 2'd0;
        orange_detected = 1'b0;
        build_table();
        cycle_limit = 2 * tab_valid.size() * PWM_PERIOD + 100;
        repeat (8) @(posedge clk_50);
        #2;
        rst_n = 1'b1;

        mode_check("mode", mode, mode_idle);
        cam_state_check("cam_state", cam_state, cam_pause);
        drive_check("drive_state", drive_state, drv_stop);
        display_check(letters_for(mode_idle, cam_pause, drv_stop));
        flag_check("motor_left_pwm", motor_left_pwm, 1'b0);
        flag_check("motor_right_pwm", motor_right_pwm, 1'b0);
        flag_check("motor_left_rev", motor_left_rev, 1'b0);
        flag_check("motor_right_rev", motor_right_rev, 1'b0);

        for (int i = 0; i < tab_valid.size(); i++) begin
            ir_valid        = tab_valid[i];
            ir_code         = ir_code_e'(tab_code[i]);
            cam_direction   = tab_dir[i];
            speed           = tab_speed[i];
            orange_detected = tab_orange[i];
            @(posedge clk_50);
            #2;
            mode_check("mode", mode, tab_mode[i]);
            cam_state_check("cam_state", cam_state, tab_cam[i]);
            drive_check("drive_state", drive_state, tab_drive[i]);
            display_check(tab_hex[i]);
        end

        // Duty measurement in infrared mode with neutral levels
        ir_valid        = 1'b1;
        ir_code         = btn_ir;
        cam_direction   = dir_none;
        speed           = 2'd0;
        orange_detected = 1'b0;
        @(posedge clk_50);
        #2;
        ir_valid = 1'b0;
        mode_check("mode", mode, mode_ir);
        repeat (2) @(posedge clk_50);
        #2;
        measure_duty(btn_slow, drv_slow, PWM_PERIOD / 4, PWM_PERIOD / 4, 1'b0, 1'b0);
        measure_duty(btn_medium, drv_medium, PWM_PERIOD / 2, PWM_PERIOD / 2, 1'b0, 1'b0);
        measure_duty(btn_fast, drv_fast, PWM_PERIOD * 3 / 4, PWM_PERIOD * 3 / 4, 1'b0, 1'b0);
        measure_duty(btn_left, drv_left, 0, PWM_PERIOD / 2, 1'b0, 1'b0);
        measure_duty(btn_right, drv_right, PWM_PERIOD / 2, 0, 1'b0, 1'b0);
        measure_duty(btn_reverse, drv_reverse, PWM_PERIOD / 2, PWM_PERIOD / 2, 1'b1, 1'b1);
        measure_duty(btn_lreverse, drv_lreverse, 0, PWM_PERIOD / 2, 1'b0, 1'b1);
        measure_duty(btn_rreverse, drv_rreverse, PWM_PERIOD / 2, 0, 1'b1, 1'b0);
        measure_duty(btn_stop, drv_stop, 0, 0, 1'b0, 1'b0);

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== verilog.f ====
common/rover_pkg.sv
mode_fsm/mode_fsm.sv
rtl/motor_pwm.sv
rtl/status_display.sv
rtl/rover_top.sv
verification/rover_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the rover testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module rover_tb -f verilog.f -o rover_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/rover_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qF 'All tests passed!'; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1
